//--- io_subsystem.f
+incdir+logic
logic/io_pkg.sv
logic/io_queue.sv
logic/uart_write.sv
logic/uart_read.sv
logic/io_port_decode.sv
logic/io_subsystem.sv
sim/io_subsystem_checker.sv
sim/io_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the I/O subsystem testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f io_subsystem.f \
	--top-module io_subsystem_tb -o io_subsystem_sim

out=$(./obj_dir/io_subsystem_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED'; then
	exit 0
fi
exit 1

//--- sim/io_subsystem_tb.sv
/*
 * Testbench for io_subsystem acting as the Wishbone master of the core.
 * rxd follows txd in loopback mode, or a driven line while frames are injected.
 * Data port reads first poll status bit 0, so they follow serial timing.
 */
`timescale 1ns/10ps
`default_nettype none

module io_subsystem_tb import io_pkg::*; ();
	`include "io_defs.svh"

	localparam int ack_limit  = 40 * `IO_CLKS_PER_BIT; // Covers a stalled write
	localparam int poll_limit = 400;
	localparam int int_limit  = 20 * `IO_CLKS_PER_BIT;

	typedef enum logic [1:0] {op_write, op_read, op_inject, op_pause} op_t;

	typedef struct packed {
		op_t       op;
		io_addr_t  addr;
		word_t     data;      // Inject uses bit 8 as the stop bit
		word_t     exp_word;
		rx_frame_t exp_frame; // Data port reads only
	} entry_t;

	logic clock, Async_Reset, wb_cyc, wb_stb, wb_we, wb_ack;
	logic txd, rxd, clear_int, int_req;
	logic loop_mode, inject_line;
	io_addr_t wb_adr, int_address;
	word_t wb_dat_w, wb_dat_r;

	entry_t stim[$];
	int test_count, check_count, error_count;

	assign rxd = loop_mode ? txd : inject_line;

	io_subsystem UUT (
		.clock(clock), .Async_Reset(Async_Reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.txd(txd), .rxd(rxd), .clear_int(clear_int),
		.int_req(int_req), .int_address(int_address)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_frame(input string name, input rx_frame_t expected,
			input rx_frame_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %0t %s expected err=%b data=%h actual err=%b data=%h", $time,
				name, expected.framing_error, expected.data, actual.framing_error, actual.data);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %0t %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	// One Wishbone classic access, request held until ack
	task automatic bus_access(input logic we, input io_addr_t adr, input word_t dat,
			output word_t rdata, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		rdata = '0;
		@(posedge clock);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		while (!ok && cycles < ack_limit) begin
			@(posedge clock);
			cycles++;
			if (wb_ack) begin
				ok = 1'b1;
				rdata = wb_dat_r;
			end
		end
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		if (!ok) begin
			error_count++;
			$display("Timeout: no ack from address %h within %0d cycles", adr, ack_limit);
		end
	endtask

	task automatic wait_rx_ready(output logic ready);
		word_t status;
		logic ok;
		int polls;
		ready = 1'b0;
		polls = 0;
		while (!ready && polls < poll_limit) begin
			bus_access(1'b0, `IO_UART_STATUS_ADDRESS, '0, status, ok);
			polls++;
			ready = ok & status[0];
		end
		if (!ready) begin
			error_count++;
			$display("Timeout: receive queue stayed empty after %0d status polls", poll_limit);
		end
	endtask

	task automatic wait_int_req(output logic seen);
		int cycles;
		cycles = 0;
		seen = int_req;
		while (!seen && cycles < int_limit) begin
			@(posedge clock);
			cycles++;
			seen = int_req;
		end
		if (!seen) begin
			error_count++;
			$display("Timeout: int_req did not rise within %0d cycles", int_limit);
		end
	endtask

	// Serial frame on the injection line, LSB first
	task automatic drive_frame(input byte_t data, input logic stop_bit);
		@(posedge clock);
		loop_mode   <= 1'b0;
		inject_line <= 1'b0;
		repeat (`IO_CLKS_PER_BIT) @(posedge clock);
		for (int k = 0; k < 8; k++) begin
			inject_line <= data[k];
			repeat (`IO_CLKS_PER_BIT) @(posedge clock);
		end
		inject_line <= stop_bit;
		repeat (`IO_CLKS_PER_BIT) @(posedge clock);
		inject_line <= 1'b1;
		repeat (2 * `IO_CLKS_PER_BIT) @(posedge clock); // Idle gap before loopback
		loop_mode <= 1'b1;
	endtask

	task automatic pulse_clear();
		@(posedge clock);
		clear_int <= 1'b1;
		@(posedge clock);
		clear_int <= 1'b0;
		@(posedge clock);
		check_bit("int_req", 1'b0, int_req);
	endtask

	task automatic read_frame(input rx_frame_t expected);
		word_t rdata;
		logic ok;
		wait_rx_ready(ok);
		if (ok) begin
			bus_access(1'b0, `IO_UART_DATA_ADDRESS, '0, rdata, ok);
			if (ok) check_frame("wb_dat_r frame", expected, rx_frame_t'(rdata[8:0]));
		end
	endtask

	task automatic run_entry(input entry_t e);
		word_t rdata;
		logic ok;
		case (e.op)
			op_write: begin
				bus_access(1'b1, e.addr, e.data, rdata, ok);
				if (ok && e.addr == `IO_INT_VECTOR_ADDRESS)
					check_word("int_address", {16'b0, e.data[15:0]}, {16'b0, int_address});
			end
			op_read: begin
				if (e.addr == `IO_UART_DATA_ADDRESS) read_frame(e.exp_frame);
				else begin
					bus_access(1'b0, e.addr, '0, rdata, ok);
					if (ok) check_word("wb_dat_r", e.exp_word, rdata);
				end
			end
			op_inject: drive_frame(e.data[7:0], e.data[8]);
			default: repeat (e.data) @(posedge clock); // Let the line go idle
		endcase
	endtask

	function automatic void add_entry(input op_t op, input io_addr_t addr, input word_t data,
			input word_t exp_word, input rx_frame_t exp_frame);
		entry_t e;
		e.op        = op;
		e.addr      = addr;
		e.data      = data;
		e.exp_word  = exp_word;
		e.exp_frame = exp_frame;
		stim.push_back(e);
	endfunction

	function automatic string op_label(input op_t op);
		case (op)
			op_write:  return "write";
			op_read:   return "read";
			op_inject: return "inject";
			default:   return "pause";
		endcase
	endfunction

	task automatic report_test(input string label, input int errors_before);
		test_count++;
		$display("test %0d %s: %s", test_count, label,
			(error_count == errors_before) ? "ok" : "error");
	endtask

	initial begin
		byte_t loop_bytes[4];
		byte_t burst_bytes[6];
		byte_t irq_byte;
		logic ok;
		int errors_before;
		void'($urandom(57818));
		{wb_cyc, wb_stb, wb_we, clear_int} <= 4'b0;
		wb_adr      <= '0;
		wb_dat_w    <= '0;
		loop_mode   <= 1'b1;
		inject_line <= 1'b1;
		Async_Reset <= 1'b0;
		repeat (16) @(posedge clock);
		Async_Reset <= 1'b1;
		@(posedge clock);

		errors_before = error_count;
		check_bit("txd", 1'b1, txd);
		check_bit("int_req", 1'b0, int_req);
		check_word("int_address", '0, {16'b0, int_address});
		report_test("reset state", errors_before);

		for (int k = 0; k < 4; k++) loop_bytes[k] = byte_t'($urandom());
		for (int k = 0; k < 6; k++) burst_bytes[k] = byte_t'($urandom());

		add_entry(op_read, `IO_INT_VECTOR_ADDRESS, '0, '0, '0);
		add_entry(op_read, `IO_UART_STATUS_ADDRESS, '0, '0, '0);
		add_entry(op_write, `IO_INT_VECTOR_ADDRESS, 32'hABCD_1234, '0, '0);
		add_entry(op_read, `IO_INT_VECTOR_ADDRESS, '0, 32'h0000_1234, '0);
		add_entry(op_write, 16'h1000, 32'h5555_AAAA, '0, '0);
		add_entry(op_read, 16'h1000, '0, '0, '0);
		add_entry(op_read, `IO_INT_VECTOR_ADDRESS, '0, 32'h0000_1234, '0);
		for (int k = 0; k < 4; k++)
			add_entry(op_write, `IO_UART_DATA_ADDRESS, {24'b0, loop_bytes[k]}, '0, '0);
		for (int k = 0; k < 4; k++)
			add_entry(op_read, `IO_UART_DATA_ADDRESS, '0, '0, {1'b0, loop_bytes[k]});
		add_entry(op_pause, '0, 2 * `IO_CLKS_PER_BIT, '0, '0);
		add_entry(op_read, `IO_UART_STATUS_ADDRESS, '0, '0, '0);
		for (int k = 0; k < 5; k++)
			add_entry(op_write, `IO_UART_DATA_ADDRESS, {24'b0, burst_bytes[k]}, '0, '0);
		add_entry(op_read, `IO_UART_STATUS_ADDRESS, '0, 32'h6, '0); // Full and busy
		add_entry(op_write, `IO_UART_DATA_ADDRESS, {24'b0, burst_bytes[5]}, '0, '0);
		for (int k = 0; k < 6; k++)
			add_entry(op_read, `IO_UART_DATA_ADDRESS, '0, '0, {1'b0, burst_bytes[k]});
		add_entry(op_pause, '0, 2 * `IO_CLKS_PER_BIT, '0, '0);
		add_entry(op_read, `IO_UART_STATUS_ADDRESS, '0, '0, '0);
		add_entry(op_inject, '0, 32'h0000_00A5, '0, '0); // Stop bit low
		add_entry(op_read, `IO_UART_DATA_ADDRESS, '0, '0, {1'b1, 8'hA5});
		add_entry(op_inject, '0, 32'h0000_013C, '0, '0);
		add_entry(op_read, `IO_UART_DATA_ADDRESS, '0, '0, {1'b0, 8'h3C});

		foreach (stim[n]) begin
			errors_before = error_count;
			run_entry(stim[n]);
			report_test($sformatf("%s at %h", op_label(stim[n].op), stim[n].addr),
				errors_before);
		end

		// Latch still set from the frames above
		errors_before = error_count;
		check_bit("int_req", 1'b1, int_req);
		pulse_clear();
		repeat (`IO_CLKS_PER_BIT) @(posedge clock);
		check_bit("int_req", 1'b0, int_req);
		irq_byte = byte_t'($urandom());
		drive_frame(irq_byte, 1'b1);
		wait_int_req(ok);
		read_frame({1'b0, irq_byte});
		check_bit("int_req", 1'b1, int_req); // Data read leaves the latch set
		pulse_clear();
		report_test("interrupt latch", errors_before);

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/io_subsystem_checker.sv
/*
 * Bus and interrupt assertions, bound into every io_subsystem instance.
 * All properties are ignored while Async_Reset is low.
 */
`timescale 1ns/10ps
`default_nettype none

module io_subsystem_checker (
	input wire logic clock,
	input wire logic Async_Reset,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_ack,
	input wire logic clear_int,
	input wire logic int_req,
	input wire logic txd,
	input wire logic tx_busy
);
	ack_inside_cycle: assert property (@(posedge clock) disable iff (!Async_Reset)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack high outside an active bus cycle");

	ack_single_cycle: assert property (@(posedge clock) disable iff (!Async_Reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high two cycles in a row");

	// Clear has priority over a new frame
	clear_drops_int: assert property (@(posedge clock) disable iff (!Async_Reset)
		clear_int |=> !int_req)
		else $error("int_req still high after clear_int");

	idle_line_high: assert property (@(posedge clock) disable iff (!Async_Reset)
		!tx_busy |-> txd)
		else $error("txd low while the transmitter is idle");

endmodule

bind io_subsystem io_subsystem_checker bus_checks (
	.clock(clock),
	.Async_Reset(Async_Reset),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.clear_int(clear_int),
	.int_req(int_req),
	.txd(txd),
	.tx_busy(tx_busy)
);

`default_nettype wire

//--- logic/io_subsystem.sv
/*
 * I/O block top level with the bus port, queues and both UART directions.
 * A full receive queue drops new frames but still raises the interrupt.
 */
`timescale 1ns/10ps
`default_nettype none

module io_subsystem import io_pkg::*; (
	input  wire logic     clock,
	input  wire logic     Async_Reset,
	input  wire logic     wb_cyc,
	input  wire logic     wb_stb,
	input  wire logic     wb_we,
	input  wire io_addr_t wb_adr,
	input  wire word_t    wb_dat_w,
	output word_t         wb_dat_r,
	output logic          wb_ack,
	output logic          txd,
	input  wire logic     rxd,
	input  wire logic     clear_int,
	output logic          int_req,
	output io_addr_t      int_address
);
	`include "io_defs.svh"

	logic tx_push, tx_pop, tx_empty, tx_full, tx_busy;
	byte_t tx_data, tx_head;
	logic rx_push, rx_pop, rx_empty, rx_valid;
	rx_frame_t rx_frame, rx_head;

	io_port_decode decode (
		.clock, .Async_Reset,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.tx_full, .tx_busy, .rx_empty, .rx_head, .rx_valid, .clear_int,
		.tx_push, .tx_data, .rx_pop, .int_req, .int_address
	);

	io_queue #(.payload_t(byte_t), .DEPTH(`IO_TX_DEPTH)) tx_queue (
		.clock, .Async_Reset,
		.push(tx_push), .push_data(tx_data), .pop(tx_pop),
		.head(tx_head), .empty(tx_empty), .full(tx_full)
	);

	io_queue #(.payload_t(rx_frame_t), .DEPTH(`IO_RX_DEPTH)) rx_queue (
		.clock, .Async_Reset,
		.push(rx_push), .push_data(rx_frame), .pop(rx_pop),
		.head(rx_head), .empty(rx_empty), .full() // Full only drops frames
	);

	uart_write uwrite (
		.clock, .Async_Reset, .tx_empty, .tx_head, .tx_pop, .txd, .tx_busy
	);

	uart_read uread (
		.clock, .Async_Reset, .rxd, .rx_push, .rx_frame, .rx_valid
	);

endmodule

`default_nettype wire

//--- logic/io_port_decode.sv
/*
 * Wishbone classic slave for the UART data, status and vector ports.
 * Each access is acknowledged once, one cycle after the request.
 * A data port write stalls while the transmit queue is full.
 * Reading the data port pops the receive queue, or returns zero if it is empty.
 * The interrupt latch gives clear_int priority over a new frame.
 */
`timescale 1ns/10ps
`default_nettype none

module io_port_decode import io_pkg::*; (
	input  wire logic      clock,
	input  wire logic      Async_Reset,
	input  wire logic      wb_cyc,
	input  wire logic      wb_stb,
	input  wire logic      wb_we,
	input  wire io_addr_t  wb_adr,
	input  wire word_t     wb_dat_w,
	input  wire logic      tx_full,
	input  wire logic      tx_busy,
	input  wire logic      rx_empty,
	input  wire rx_frame_t rx_head,
	input  wire logic      rx_valid,
	input  wire logic      clear_int,
	output word_t          wb_dat_r,
	output logic           wb_ack,
	output logic           tx_push,
	output byte_t          tx_data,
	output logic           rx_pop,
	output logic           int_req,
	output io_addr_t       int_address
);
	`include "io_defs.svh"

	logic req, is_data, is_status, is_vector, stall, ack_next;
	word_t status_word, read_word;

	assign req       = wb_cyc & wb_stb & ~wb_ack; // No second ack for the same access
	assign is_data   = (wb_adr == `IO_UART_DATA_ADDRESS);
	assign is_status = (wb_adr == `IO_UART_STATUS_ADDRESS);
	assign is_vector = (wb_adr == `IO_INT_VECTOR_ADDRESS);

	assign stall    = is_data & wb_we & tx_full; // Hold off until a slot frees
	assign ack_next = req & ~stall;

	// Queue strobes fire on the edge that raises ack
	assign tx_push = ack_next & wb_we & is_data;
	assign tx_data = wb_dat_w[7:0];
	assign rx_pop  = ack_next & ~wb_we & is_data & ~rx_empty;

	assign status_word = {29'b0, tx_busy, tx_full, ~rx_empty};

	always_comb begin
		read_word = '0; // Unmapped and empty reads give zero
		if (is_data && !rx_empty) read_word = {23'b0, rx_head};
		else if (is_status) read_word = status_word;
		else if (is_vector) read_word = {16'b0, int_address};
	end

	always_ff @(posedge clock) begin
		if (ack_next && !wb_we) wb_dat_r <= read_word;
	end

	always_ff @(posedge clock or negedge Async_Reset) begin
		if (!Async_Reset) begin
			wb_ack      <= 1'b0;
			int_address <= '0;
			int_req     <= 1'b0;
		end else begin
			wb_ack <= ack_next;
			if (ack_next && wb_we && is_vector)
				int_address <= wb_dat_w[15:0];
			if (clear_int) int_req <= 1'b0; // Clear wins
			else if (rx_valid) int_req <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/uart_read.sv
/*
 * 8N1 serial receiver. rxd passes a two-stage synchronizer first.
 * The start bit is rechecked at mid-period and a glitch is ignored.
 * Every frame is pushed in the middle of its stop bit, with the
 * framing error flag set when the stop bit reads low.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_read import io_pkg::*; (
	input  wire logic clock,
	input  wire logic Async_Reset,
	input  wire logic rxd,
	output logic      rx_push,
	output rx_frame_t rx_frame,
	output logic      rx_valid
);
	`include "io_defs.svh"

	localparam int tick_w = $clog2(`IO_CLKS_PER_BIT);
	localparam logic [tick_w-1:0] last_tick = tick_w'(`IO_CLKS_PER_BIT - 1);
	localparam logic [tick_w-1:0] mid_tick  = tick_w'(`IO_CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

	rx_state_t state;
	logic [1:0] rxd_sync;
	logic rxd_s;
	logic [tick_w-1:0] tick;
	logic [2:0] bit_idx;
	byte_t shifter;
	logic frame_done;

	assign rxd_s    = rxd_sync[1];
	assign rx_push  = frame_done;
	assign rx_valid = frame_done; // Same pulse raises the interrupt

	always_ff @(posedge clock or negedge Async_Reset) begin
		if (!Async_Reset) rxd_sync <= 2'b11; // Line idles high
		else rxd_sync <= {rxd_sync[0], rxd};
	end

	always_ff @(posedge clock) begin
		if (state == st_data && tick == last_tick)
			shifter <= {rxd_s, shifter[7:1]};
		if (state == st_stop && tick == last_tick) begin
			rx_frame.framing_error <= ~rxd_s;
			rx_frame.data          <= shifter;
		end
	end

	always_ff @(posedge clock or negedge Async_Reset) begin
		if (!Async_Reset) begin
			state      <= st_idle;
			tick       <= '0;
			bit_idx    <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				st_idle: begin
					tick    <= '0;
					bit_idx <= '0;
					if (!rxd_s) state <= st_start; // Falling edge of start
				end
				st_start: begin
					if (tick != mid_tick) tick <= tick + 1'b1;
					else begin
						tick  <= '0;
						state <= rxd_s ? st_idle : st_data; // False start goes back
					end
				end
				st_data: begin
					if (tick != last_tick) tick <= tick + 1'b1;
					else begin
						tick    <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= st_stop;
					end
				end
				default: begin
					if (tick != last_tick) tick <= tick + 1'b1;
					else begin
						tick       <= '0;
						frame_done <= 1'b1;
						state      <= st_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/uart_write.sv
/*
 * 8N1 serial transmitter fed from a byte queue.
 * A byte is popped as its start bit begins, so frames run back to back
 * with one idle cycle between them. The line idles high.
 */
`timescale 1ns/10ps
`default_nettype none

module uart_write import io_pkg::*; (
	input  wire logic  clock,
	input  wire logic  Async_Reset,
	input  wire logic  tx_empty,
	input  wire byte_t tx_head,
	output logic       tx_pop,
	output logic       txd,
	output logic       tx_busy
);
	`include "io_defs.svh"

	localparam int tick_w = $clog2(`IO_CLKS_PER_BIT);
	localparam logic [tick_w-1:0] last_tick = tick_w'(`IO_CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} tx_state_t;

	tx_state_t state;
	logic [tick_w-1:0] tick;
	logic [2:0] bit_idx;
	byte_t shifter;

	assign tx_pop  = (state == st_idle) & ~tx_empty; // Take head as frame starts
	assign tx_busy = (state != st_idle);

	always_ff @(posedge clock) begin
		if (tx_pop) shifter <= tx_head;
		else if (state != st_idle && tick == last_tick && state != st_stop)
			shifter <= {1'b0, shifter[7:1]}; // LSB goes out first
	end

	always_ff @(posedge clock or negedge Async_Reset) begin
		if (!Async_Reset) begin
			state   <= st_idle;
			tick    <= '0;
			bit_idx <= '0;
			txd     <= 1'b1;
		end else if (state == st_idle) begin
			tick    <= '0;
			bit_idx <= '0;
			if (tx_pop) begin
				state <= st_start;
				txd   <= 1'b0; // Start bit
			end
		end else if (tick != last_tick) begin
			tick <= tick + 1'b1;
		end else begin
			tick <= '0;
			case (state)
				st_start: begin
					state <= st_data;
					txd   <= shifter[0];
				end
				st_data: begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) begin
						state <= st_stop;
						txd   <= 1'b1; // Stop bit
					end else begin
						txd <= shifter[0];
					end
				end
				default: state <= st_idle; // End of stop bit
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/io_queue.sv
/*
 * Circular FIFO with a registered count.
 * Push while full and pop while empty are silently dropped.
 * The head is valid only while the queue is not empty.
 */
`timescale 1ns/10ps
`default_nettype none

module io_queue #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  wire logic     clock,
	input  wire logic     Async_Reset,
	input  wire logic     push,
	input  wire payload_t push_data,
	input  wire logic     pop,
	output payload_t      head,
	output logic          empty,
	output logic          full
);
	localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cnt_w = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [ptr_w-1:0] wr_ptr, rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_push, do_pop;

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(DEPTH - 1)) ? '0 : ptr + 1'b1; // Wrap at last slot
	endfunction

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign empty   = (count == '0);
	assign full    = (count == cnt_w'(DEPTH));
	assign head    = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clock or negedge Async_Reset) begin
		if (!Async_Reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= next_ptr(wr_ptr);
			if (do_pop) rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/io_pkg.sv
/*
 * Shared types for the bus side and the UART side of the I/O block.
 * The UART frame format is fixed at 8N1.
 */
`default_nettype none

package io_pkg;

	typedef logic [31:0] word_t;    // Bus data word
	typedef logic [15:0] io_addr_t; // Port address
	typedef logic [7:0]  byte_t;    // Serial payload

	// Received frame, error flag lands in bit 8 of a data port read
	typedef struct packed {
		logic  framing_error; // Stop bit sampled low
		byte_t data;
	} rx_frame_t;

	// Status word layout as seen on a status port read
	//   bit 0 receive queue not empty
	//   bit 1 transmit queue full
	//   bit 2 transmitter busy
	//   upper bits read as zero

endpackage

`default_nettype wire

//--- logic/io_defs.svh
/*
 * Port map and serial timing for the memory-mapped I/O block.
 * Ports are decoded on the full 16-bit address, with no aliasing.
 * The bit period is counted in clock cycles and should be even,
 * so that the receiver lands on the middle of each bit.
 */
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// Port addresses, one word each
`define IO_UART_DATA_ADDRESS   16'hFFFC
`define IO_UART_STATUS_ADDRESS 16'hFFF4
`define IO_INT_VECTOR_ADDRESS  16'hFFF8

// Clock cycles per serial bit
`define IO_CLKS_PER_BIT 16

// Queue depths in entries
`define IO_TX_DEPTH 4
`define IO_RX_DEPTH 8

`endif
